//--- Bender.yml
package:
  name: man_rx

sources:
  - man_pkg.sv
  - man_line_decoder.sv
  - man_frame_deser.sv
  - man_rx_fifo.sv
  - man_axil_regs.sv
  - man_rx_top.sv
  - target: test
    files:
      - man_rx_asserts.sv
      - tb_man_rx.sv

//--- man_axil_regs.sv
// AXI4-Lite slave with 4-bit addresses, one outstanding read and one outstanding write; AW and W must arrive together
module man_axil_regs (
    input  logic               clk,
    input  logic               rst_n,
    input  man_pkg::axil_req_t axil_req,
    output man_pkg::axil_rsp_t axil_rsp,
    input  logic [7:0]         head,
    input  logic [7:0]         count,
    input  logic               overflow,
    input  logic [7:0]         frame_cnt,
    input  logic               in_frame,
    input  logic               trunc_pulse,
    output logic               pop,
    output logic               clr_overflow,
    output logic               enable
);

    import man_pkg::*;

    logic        bvalid;
    logic        rvalid;
    logic [1:0]  bresp;
    logic [1:0]  rresp;
    logic [31:0] rdata;
    logic        trunc_err;
    logic        wr_fire;
    logic        rd_fire;
    logic        sts_wr;
    logic [1:0]  wr_resp;
    logic [1:0]  rd_resp;
    logic [31:0] rd_word;
    man_status_t status;

    assign wr_fire      = axil_req.awvalid && axil_req.wvalid && !bvalid;
    assign rd_fire      = axil_req.arvalid && !rvalid;
    assign sts_wr       = wr_fire && (axil_req.awaddr == REG_STATUS) && axil_req.wstrb[1];
    assign clr_overflow = sts_wr && axil_req.wdata[9];
    // empty FIFO reads pop nothing
    assign pop          = rd_fire && (axil_req.araddr == REG_DATA) && (count != 8'd0);

    always_comb begin
        status            = '0;
        status.fifo_count = count;
        status.empty      = (count == 8'd0);
        status.overflow   = overflow;
        status.trunc_err  = trunc_err;
        status.frame_cnt  = frame_cnt;
        status.in_frame   = in_frame;
    end

    always_comb begin
        rd_word = '0;
        rd_resp = RESP_OKAY;
        case (axil_req.araddr)
            REG_DATA: begin
                if (count != 8'd0) begin
                    rd_word = {24'd0, head};
                end else begin
                    rd_resp = RESP_SLVERR;
                end
            end
            REG_STATUS: rd_word = status;
            REG_CTRL:   rd_word = {31'd0, enable};
            default:    rd_resp = RESP_SLVERR;
        endcase
    end

    // DATA is read only
    assign wr_resp = ((axil_req.awaddr == REG_STATUS) || (axil_req.awaddr == REG_CTRL)) ?
                     RESP_OKAY : RESP_SLVERR;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bvalid    <= 1'b0;
            rvalid    <= 1'b0;
            enable    <= 1'b1;
            trunc_err <= 1'b0;
        end else begin
            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (axil_req.bready) begin
                bvalid <= 1'b0;
            end
            if (rd_fire) begin
                rvalid <= 1'b1;
            end else if (axil_req.rready) begin
                rvalid <= 1'b0;
            end
            if (wr_fire && (axil_req.awaddr == REG_CTRL) && axil_req.wstrb[0]) begin
                enable <= axil_req.wdata[0];
            end
            if (trunc_pulse) begin
                trunc_err <= 1'b1;
            end else if (sts_wr && axil_req.wdata[10]) begin
                trunc_err <= 1'b0;
            end
        end
    end

    // response payload, held while valid waits for ready
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            bresp <= wr_resp;
        end
        if (rd_fire) begin
            rresp <= rd_resp;
            rdata <= rd_word;
        end
    end

    always_comb begin
        axil_rsp         = '0;
        axil_rsp.awready = wr_fire;
        axil_rsp.wready  = wr_fire;
        axil_rsp.bvalid  = bvalid;
        axil_rsp.bresp   = bresp;
        axil_rsp.arready = !rvalid;
        axil_rsp.rvalid  = rvalid;
        axil_rsp.rdata   = rdata;
        axil_rsp.rresp   = rresp;
    end

endmodule

//--- man_frame_deser.sv
// bytes arrive MSB first after SYNC_BYTE; each byte is held until the next bit or idle so last can be marked
module man_frame_deser (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               enable,
    input  man_pkg::man_bit_t  bit_in,
    output man_pkg::man_byte_t byte_out,
    output logic [7:0]         frame_cnt,
    output logic               in_frame,
    output logic               trunc_pulse
);

    import man_pkg::*;

    logic [7:0] shreg;
    logic [7:0] shifted;
    logic [2:0] bit_cnt;      // bits of the byte in progress
    logic [7:0] held;
    logic       held_valid;
    logic       byte_done;

    assign shifted   = {shreg[6:0], bit_in.value};
    assign byte_done = enable && !bit_in.idle && bit_in.valid && in_frame && (bit_cnt == 3'd7);

    always_ff @(posedge clk) begin
        if (byte_done) begin
            held <= shifted;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            shreg       <= '0;
            bit_cnt     <= '0;
            held_valid  <= 1'b0;
            in_frame    <= 1'b0;
            frame_cnt   <= '0;
            trunc_pulse <= 1'b0;
            byte_out    <= '0;
        end else begin
            byte_out    <= '0;
            trunc_pulse <= 1'b0;
            if (!enable) begin
                // drop whatever was in flight, back to hunting
                shreg      <= '0;
                bit_cnt    <= '0;
                held_valid <= 1'b0;
                in_frame   <= 1'b0;
            end else if (bit_in.idle) begin
                if (in_frame) begin
                    byte_out.valid <= held_valid;
                    byte_out.data  <= held;
                    byte_out.last  <= held_valid;
                    frame_cnt      <= frame_cnt + 8'd1;
                    trunc_pulse    <= (bit_cnt != 3'd0);   // partial byte
                end
                shreg      <= '0;
                bit_cnt    <= '0;
                held_valid <= 1'b0;
                in_frame   <= 1'b0;
            end else if (bit_in.valid) begin
                shreg <= shifted;
                if (!in_frame) begin
                    if (shifted == SYNC_BYTE) begin
                        in_frame <= 1'b1;
                        bit_cnt  <= '0;
                    end
                end else begin
                    if (held_valid) begin
                        // more bits follow, so the held byte is not last
                        byte_out.valid <= 1'b1;
                        byte_out.data  <= held;
                        held_valid     <= 1'b0;
                    end
                    if (byte_done) begin
                        held_valid <= 1'b1;
                    end
                    bit_cnt <= bit_cnt + 3'd1;   // wraps after eight
                end
            end
        end
    end

endmodule

//--- man_line_decoder.sv
// line must sit at a constant level between frames; bit period within about 10 % of 2*HALF_BIT_CYCLES clocks
module man_line_decoder #(
    parameter int HALF_BIT_CYCLES = 8
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              line,
    input  logic              enable,
    output man_pkg::man_bit_t bit_out
);

    // next mid-bit is two half-bits away, a boundary edge only one
    localparam int GATE_CYCLES = (3 * HALF_BIT_CYCLES) / 2;
    localparam int IDLE_CYCLES = 4 * HALF_BIT_CYCLES;
    localparam int CNT_W       = $clog2(IDLE_CYCLES + 1);

    logic             line_s1;
    logic             line_s2;
    logic             line_prev;
    logic             line_edge;
    logic             locked;     // a mid-bit edge was accepted recently
    logic [CNT_W-1:0] cnt;        // cycles since last accepted edge
    logic             gate_open;

    // two-flop synchronizer plus one delayed copy for edge detect
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            line_s1   <= 1'b0;
            line_s2   <= 1'b0;
            line_prev <= 1'b0;
        end else begin
            line_s1   <= line;
            line_s2   <= line_s1;
            line_prev <= line_s2;
        end
    end

    assign line_edge = line_s2 ^ line_prev;
    assign gate_open = !locked || (cnt >= CNT_W'(GATE_CYCLES));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            locked  <= 1'b0;
            cnt     <= '0;
            bit_out <= '0;
        end else begin
            bit_out <= '0;
            if (!enable) begin
                locked <= 1'b0;
                cnt    <= '0;
            end else if (line_edge && gate_open) begin
                // mid-bit edge, value is the new level
                bit_out.valid <= 1'b1;
                bit_out.value <= line_s2;
                locked        <= 1'b1;
                cnt           <= '0;
            end else if (locked) begin
                if (cnt == CNT_W'(IDLE_CYCLES - 1)) begin
                    bit_out.idle <= 1'b1;   // once per quiet spell
                    locked       <= 1'b0;
                    cnt          <= '0;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

endmodule

//--- man_pkg.sv
// shared types for the Manchester receiver; AXI4-Lite addresses are 4 bits wide, so only three registers decode
package man_pkg;

    typedef struct packed {
        logic valid;
        logic value;
        logic idle;
    } man_bit_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] data;
        logic       last;   // final byte of a frame
    } man_byte_t;

    // bit 9 overflow and bit 10 trunc_err are write-1-to-clear
    typedef struct packed {
        logic [11:0] reserved;
        logic        in_frame;
        logic [7:0]  frame_cnt;
        logic        trunc_err;
        logic        overflow;
        logic        empty;
        logic [7:0]  fifo_count;
    } man_status_t;

    typedef struct packed {
        logic        awvalid;
        logic [3:0]  awaddr;
        logic        wvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        bready;
        logic        arvalid;
        logic [3:0]  araddr;
        logic        rready;
    } axil_req_t;

    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic [1:0]  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axil_rsp_t;

    localparam logic [3:0] REG_DATA   = 4'h0;
    localparam logic [3:0] REG_STATUS = 4'h4;
    localparam logic [3:0] REG_CTRL   = 4'h8;

    localparam logic [7:0] SYNC_BYTE = 8'hD5;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

//--- man_rx_asserts.sv
// bound once into man_rx_top; R and B must hold under back-pressure, FIFO occupancy stays in range
module man_rx_asserts #(
    parameter int FIFO_DEPTH = 16
) (
    input logic        clk,
    input logic        rst_n,
    input logic        rvalid,
    input logic        rready,
    input logic [31:0] rdata,
    input logic        bvalid,
    input logic        bready,
    input logic [7:0]  count,
    input logic        pop,
    input logic        push_valid
);

    timeunit 1ns;
    timeprecision 1ps;

    int fail_cnt = 0;

    assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata))
    else begin
        $error("read response dropped or changed before rready");
        fail_cnt++;
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid)
    else begin
        $error("write response dropped before bready");
        fail_cnt++;
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        count <= 8'(FIFO_DEPTH))
    else begin
        $error("FIFO count above depth");
        fail_cnt++;
    end

    // a pop without a push removes exactly one byte, so an empty FIFO is never popped
    assert property (@(posedge clk) disable iff (!rst_n)
        pop && !push_valid |=> count == $past(count) - 8'd1)
    else begin
        $error("pop while FIFO empty or pop lost");
        fail_cnt++;
    end

endmodule

bind man_rx_top man_rx_asserts #(
    .FIFO_DEPTH(FIFO_DEPTH)
) u_rx_chk (
    .clk       (clk),
    .rst_n     (rst_n),
    .rvalid    (axil_rsp.rvalid),
    .rready    (axil_req.rready),
    .rdata     (axil_rsp.rdata),
    .bvalid    (axil_rsp.bvalid),
    .bready    (axil_req.bready),
    .count     (fifo_count),
    .pop       (pop),
    .push_valid(rx_byte.valid)
);

//--- man_rx_fifo.sv
// FIFO_DEPTH must be a power of two from 2 to 128; a push into a full FIFO is dropped and flagged
module man_rx_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic               clk,
    input  logic               rst_n,
    input  man_pkg::man_byte_t push,
    input  logic               pop,
    input  logic               clr_overflow,
    output logic [7:0]         head,
    output logic [7:0]         count,
    output logic               overflow
);

    localparam int AW = $clog2(FIFO_DEPTH);

    logic [7:0]    mem [FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic          full;
    logic          do_push;
    logic          do_pop;

    assign full    = (count == 8'(FIFO_DEPTH));
    assign do_push = push.valid && !full;
    assign do_pop  = pop && (count != 8'd0);
    assign head    = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push.data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;   // pointers wrap with depth
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + 8'(do_push) - 8'(do_pop);
            if (push.valid && full) begin
                overflow <= 1'b1;          // set beats clear
            end else if (clr_overflow) begin
                overflow <= 1'b0;
            end
        end
    end

endmodule

//--- man_rx_top.sv
// Manchester receiver top; line is asynchronous to clk and HALF_BIT_CYCLES must be at least 4
module man_rx_top #(
    parameter int HALF_BIT_CYCLES = 8,
    parameter int FIFO_DEPTH      = 16
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               line,
    input  man_pkg::axil_req_t axil_req,
    output man_pkg::axil_rsp_t axil_rsp
);

    import man_pkg::*;

    man_bit_t   dec_bit;
    man_byte_t  rx_byte;
    logic [7:0] frame_cnt;
    logic       in_frame;
    logic       trunc_pulse;
    logic [7:0] fifo_head;
    logic [7:0] fifo_count;
    logic       fifo_overflow;
    logic       pop;
    logic       clr_overflow;
    logic       enable;

    man_line_decoder #(
        .HALF_BIT_CYCLES(HALF_BIT_CYCLES)
    ) u_decoder (
        .clk    (clk),
        .rst_n  (rst_n),
        .line   (line),
        .enable (enable),
        .bit_out(dec_bit)
    );

    man_frame_deser u_deser (
        .clk        (clk),
        .rst_n      (rst_n),
        .enable     (enable),
        .bit_in     (dec_bit),
        .byte_out   (rx_byte),
        .frame_cnt  (frame_cnt),
        .in_frame   (in_frame),
        .trunc_pulse(trunc_pulse)
    );

    man_rx_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_fifo (
        .clk         (clk),
        .rst_n       (rst_n),
        .push        (rx_byte),
        .pop         (pop),
        .clr_overflow(clr_overflow),
        .head        (fifo_head),
        .count       (fifo_count),
        .overflow    (fifo_overflow)
    );

    man_axil_regs u_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .axil_req    (axil_req),
        .axil_rsp    (axil_rsp),
        .head        (fifo_head),
        .count       (fifo_count),
        .overflow    (fifo_overflow),
        .frame_cnt   (frame_cnt),
        .in_frame    (in_frame),
        .trunc_pulse (trunc_pulse),
        .pop         (pop),
        .clr_overflow(clr_overflow),
        .enable      (enable)
    );

endmodule

//--- tb.f
man_pkg.sv
man_line_decoder.sv
man_frame_deser.sv
man_rx_fifo.sv
man_axil_regs.sv
man_rx_top.sv
man_rx_asserts.sv
tb_man_rx.sv

//--- tb_man_rx.sv
// testbench for man_rx_top at 16 clocks per bit; line idles high between frames, FIFO depth 16
module tb_man_rx;

    timeunit 1ns;
    timeprecision 1ps;

    import man_pkg::*;

    localparam int HALF_BIT = 8;
    localparam int DEPTH    = 16;
    localparam int TIMEOUT  = 200;     // clocks per handshake wait

    localparam logic [1:0] KIND_BYTE   = 2'd0;
    localparam logic [1:0] KIND_STATUS = 2'd1;
    localparam logic [1:0] KIND_RESP   = 2'd2;

    typedef struct packed {
        logic [1:0]  kind;
        logic [31:0] data;
        logic [1:0]  resp;
    } obs_t;

    logic        clk;
    logic        rst_n;
    logic        line;
    axil_req_t   axil_req;
    axil_rsp_t   axil_rsp;

    logic [31:0] rng = 32'd81015;
    bit          tx_bits[$];
    obs_t        got_q[$];
    obs_t        exp_q[$];
    int          n_checked = 0;

    // model of the receiver as the host sees it
    logic [7:0]  exp_fifo[$];
    logic        exp_overflow = 1'b0;
    logic        exp_trunc    = 1'b0;
    logic [7:0]  exp_frames   = 8'd0;
    logic        exp_enable   = 1'b1;

    man_rx_top #(
        .HALF_BIT_CYCLES(HALF_BIT),
        .FIFO_DEPTH     (DEPTH)
    ) UUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .line    (line),
        .axil_req(axil_req),
        .axil_rsp(axil_rsp)
    );

    always #2 clk = ~clk;

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            report_fail($sformatf("FAIL at %0t ns: DATA byte %02h, expected %02h",
                                  $time, got, exp));
        end
    endtask

    task automatic check_status(input man_status_t got, input man_status_t exp);
        if (got !== exp) begin
            report_fail($sformatf("FAIL at %0t ns: STATUS %08h, expected %08h",
                                  $time, got, exp));
        end
    endtask

    task automatic check_resp(input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp) begin
            report_fail($sformatf("FAIL at %0t ns: response %02b, expected %02b",
                                  $time, got, exp));
        end
    endtask

    function automatic int assert_fails();
        return UUT.u_rx_chk.fail_cnt;
    endfunction

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    function automatic void queue_byte(input logic [7:0] b);
        for (int i = 7; i >= 0; i--) begin
            tx_bits.push_back(b[i]);   // MSB first
        end
    endfunction

    function automatic void queue_frame(input int n);
        queue_byte(8'h55);
        queue_byte(SYNC_BYTE);
        for (int i = 0; i < n; i++) begin
            queue_byte(8'(next_rand()));
        end
    endfunction

    // expected effect of one frame: 1-bit sliding sync hunt, bytes after it, drop when full
    function automatic void ref_frame(input bit bits[$]);
        logic [7:0] window;
        logic [7:0] cur;
        int         nbits;
        bit         synced;
        window = '0;
        cur    = '0;
        nbits  = 0;
        synced = 1'b0;
        if (!exp_enable) begin
            return;
        end
        foreach (bits[i]) begin
            if (!synced) begin
                window = {window[6:0], bits[i]};
                synced = (window == SYNC_BYTE);
            end else begin
                cur   = {cur[6:0], bits[i]};
                nbits = nbits + 1;
                if (nbits == 8) begin
                    if (exp_fifo.size() < DEPTH) begin
                        exp_fifo.push_back(cur);
                    end else begin
                        exp_overflow = 1'b1;
                    end
                    nbits = 0;
                end
            end
        end
        if (synced) begin
            exp_frames = exp_frames + 8'd1;
            if (nbits != 0) begin
                exp_trunc = 1'b1;   // partial byte at idle
            end
        end
    endfunction

    function automatic man_status_t expected_status();
        man_status_t s;
        s            = '0;
        s.fifo_count = 8'(exp_fifo.size());
        s.empty      = (exp_fifo.size() == 0);
        s.overflow   = exp_overflow;
        s.trunc_err  = exp_trunc;
        s.frame_cnt  = exp_frames;
        return s;
    endfunction

    function automatic obs_t model_pop();
        obs_t o;
        o.kind = KIND_BYTE;
        o.data = '0;
        o.resp = RESP_SLVERR;       // empty FIFO
        if (exp_fifo.size() != 0) begin
            o.data = {24'd0, exp_fifo.pop_front()};
            o.resp = RESP_OKAY;
        end
        return o;
    endfunction

    function automatic logic [1:0] model_write(input logic [3:0] addr, input logic [31:0] data);
        if (addr == REG_STATUS) begin
            if (data[9]) begin
                exp_overflow = 1'b0;
            end
            if (data[10]) begin
                exp_trunc = 1'b0;
            end
            return RESP_OKAY;
        end
        if (addr == REG_CTRL) begin
            exp_enable = data[0];
            return RESP_OKAY;
        end
        return RESP_SLVERR;
    endfunction

    task automatic drive_half(input logic level);
        line <= level;
        repeat (HALF_BIT) @(posedge clk);
    endtask

    task automatic hold_idle(input int halves);
        line <= 1'b1;
        repeat (halves * HALF_BIT) @(posedge clk);
    endtask

    // first half inverted, second half carries the bit
    task automatic transmit();
        ref_frame(tx_bits);
        foreach (tx_bits[i]) begin
            drive_half(!tx_bits[i]);
            drive_half(tx_bits[i]);
        end
        tx_bits.delete();
        hold_idle(8);
    endtask

    task automatic send_noise(input int n);
        for (int i = 0; i < n; i++) begin
            line <= !line;
            repeat (2 + next_rand() % 5) @(posedge clk);
        end
    endtask

    task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
                              output logic [1:0] resp);
        int t;
        @(posedge clk);
        axil_req.awvalid <= 1'b1;
        axil_req.awaddr  <= addr;
        axil_req.wvalid  <= 1'b1;
        axil_req.wdata   <= data;
        axil_req.wstrb   <= 4'hF;
        t = 0;
        do begin
            @(posedge clk);
            t = t + 1;
            if (t > TIMEOUT) begin
                report_fail("timeout: write address and data were never accepted");
            end
        end while (!axil_rsp.awready);
        if (!axil_rsp.wready) begin
            report_fail("write data was not accepted together with the write address");
        end
        axil_req.awvalid <= 1'b0;
        axil_req.wvalid  <= 1'b0;
        t = 0;
        do begin
            @(posedge clk);
            t = t + 1;
            if (t > TIMEOUT) begin
                report_fail("timeout: no write response arrived");
            end
        end while (!axil_rsp.bvalid);
        axil_req.bready <= 1'b1;   // response waits one cycle first
        @(posedge clk);
        resp = axil_rsp.bresp;
        axil_req.bready <= 1'b0;
    endtask

    task automatic axil_read(input logic [3:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        int t;
        @(posedge clk);
        axil_req.arvalid <= 1'b1;
        axil_req.araddr  <= addr;
        t = 0;
        do begin
            @(posedge clk);
            t = t + 1;
            if (t > TIMEOUT) begin
                report_fail("timeout: read address was never accepted");
            end
        end while (!axil_rsp.arready);
        axil_req.arvalid <= 1'b0;
        t = 0;
        do begin
            @(posedge clk);
            t = t + 1;
            if (t > TIMEOUT) begin
                report_fail("timeout: no read data arrived");
            end
        end while (!axil_rsp.rvalid);
        axil_req.rready <= 1'b1;   // data has to hold a cycle
        @(posedge clk);
        data = axil_rsp.rdata;
        resp = axil_rsp.rresp;
        axil_req.rready <= 1'b0;
    endtask

    task automatic read_data();
        logic [31:0] d;
        logic [1:0]  r;
        axil_read(REG_DATA, d, r);
        got_q.push_back(obs_t'({KIND_BYTE, d, r}));
        exp_q.push_back(model_pop());
    endtask

    task automatic read_status();
        logic [31:0] d;
        logic [1:0]  r;
        axil_read(REG_STATUS, d, r);
        got_q.push_back(obs_t'({KIND_STATUS, d, r}));
        exp_q.push_back(obs_t'({KIND_STATUS, 32'(expected_status()), RESP_OKAY}));
    endtask

    task automatic read_unmapped(input logic [3:0] addr);
        logic [31:0] d;
        logic [1:0]  r;
        axil_read(addr, d, r);
        got_q.push_back(obs_t'({KIND_RESP, 32'd0, r}));
        exp_q.push_back(obs_t'({KIND_RESP, 32'd0, RESP_SLVERR}));
    endtask

    task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
        logic [1:0] r;
        axil_write(addr, data, r);
        got_q.push_back(obs_t'({KIND_RESP, 32'd0, r}));
        exp_q.push_back(obs_t'({KIND_RESP, 32'd0, model_write(addr, data)}));
    endtask

    // poll STATUS until the frame counter catches up with the model
    task automatic wait_frames();
        logic [31:0] d;
        logic [1:0]  r;
        man_status_t s;
        int          t;
        t = 0;
        do begin
            axil_read(REG_STATUS, d, r);
            s = d;
            t = t + 1;
            if (t > 50) begin
                report_fail("timeout: frame counter never reached the expected value");
            end
        end while (s.frame_cnt != exp_frames);
    endtask

    // poll STATUS while a frame is on the line
    task automatic wait_in_frame();
        logic [31:0] d;
        logic [1:0]  r;
        man_status_t s;
        int          t;
        t = 0;
        do begin
            axil_read(REG_STATUS, d, r);
            s = d;
            t = t + 1;
            if (t > 400) begin
                report_fail("timeout: in_frame never rose while a frame was sent");
            end
        end while (!s.in_frame);
    endtask

    always @(negedge clk) begin : compare
        obs_t g;
        obs_t e;
        if (assert_fails() != 0) begin
            report_fail("an assertion on the AXI4-Lite or FIFO side failed");
        end
        while (got_q.size() != 0) begin
            g = got_q.pop_front();
            e = exp_q.pop_front();
            check_resp(g.resp, e.resp);
            if (g.kind == KIND_BYTE) begin
                check_byte(g.data[7:0], e.data[7:0]);
            end else if (g.kind == KIND_STATUS) begin
                check_status(g.data, e.data);
            end
            n_checked = n_checked + 1;
        end
    end

    initial begin : stimulus
        int t;
        clk      = 1'b0;
        rst_n    = 1'b0;
        line     = 1'b1;
        axil_req = '0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        hold_idle(8);   // let the post-reset synchronizer edge time out

        queue_frame(10);
        fork
            transmit();
            wait_in_frame();
        join
        wait_frames();
        read_status();   // ten bytes waiting
        repeat (10) read_data();
        read_status();

        // noise, then a stray byte ahead of the preamble
        send_noise(6);
        hold_idle(8);
        queue_byte(8'h3C);
        queue_frame(5);
        transmit();
        wait_frames();
        repeat (5) read_data();
        read_status();

        queue_frame(4);
        for (int i = 0; i < 3; i++) begin
            tx_bits.push_back(1'(next_rand()));   // 3 bits of a lost byte
        end
        transmit();
        wait_frames();
        repeat (4) read_data();
        read_status();
        write_reg(REG_STATUS, 32'h0000_0400);
        read_status();

        // 20 bytes into a 16 deep FIFO
        queue_frame(12);
        transmit();
        queue_frame(8);
        transmit();
        wait_frames();
        read_status();
        repeat (16) read_data();
        read_status();
        write_reg(REG_STATUS, 32'h0000_0200);
        read_status();

        write_reg(REG_CTRL, 32'h0);
        queue_frame(6);
        transmit();
        read_status();
        write_reg(REG_CTRL, 32'h1);
        queue_frame(6);
        transmit();
        wait_frames();
        repeat (6) read_data();
        read_status();

        read_data();
        write_reg(REG_DATA, 32'h0000_00A5);
        read_unmapped(4'hC);
        read_status();

        t = 0;
        while (got_q.size() != 0) begin
            @(posedge clk);
            t = t + 1;
            if (t > TIMEOUT) begin
                report_fail("timeout: queued results were never compared");
            end
        end
        @(posedge clk);
        if (n_checked == 0 || assert_fails() != 0) begin
            report_fail("no results were compared or an assertion failed");
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule
